/* Makefile */
SRCS := $(shell grep -v '^+' sources.f)

.PHONY: all run clean

all: obj_dir/Vslow_shell_tb

obj_dir/Vslow_shell_tb: sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module slow_shell_tb \
		-o Vslow_shell_tb

run: obj_dir/Vslow_shell_tb
	./obj_dir/Vslow_shell_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/adc_minmax.sv */
`timescale 1ns/1ps

module adc_minmax (
	input  logic            clk,
	input  logic            rst_n,
	input  adc_pkg::sample_t sample,
	input  logic            slow_snap,
	output adc_pkg::sample_t adc_min,
	output adc_pkg::sample_t adc_max
);

	// Running extremes of the window in progress
	adc_pkg::sample_t run_min;
	adc_pkg::sample_t run_max;
	// Low until the first sample after reset has been taken
	logic             armed;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_min <= '0;
			run_max <= '0;
			armed   <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (slow_snap || !armed) begin
				// New window opens with the current sample
				run_min <= sample;
				run_max <= sample;
			end else begin
				// Signed compare, both sides are sample_t
				if (sample < run_min)
					run_min <= sample;
				if (sample > run_max)
					run_max <= sample;
			end
		end
	end

	// Window through the cycle before snap, frozen by the chain load at snap
	assign adc_min = run_min;
	assign adc_max = run_max;

endmodule

/* design/adc_pkg.sv */
// ADC input description shared by the min/max trackers and the readout path
package adc_pkg;

	// Bits per raw ADC sample
	localparam int sample_width = 16;

	// Field, forward and reflect streams
	localparam int num_channels = 3;

	// Raw ADC samples are two's complement
	typedef logic signed [sample_width-1:0] sample_t;

endpackage

/* design/slow_pkg.sv */
// Layout of the slow byte-serial readout frame
package slow_pkg;

	// Comparator event lines from the RF controller
	localparam int event_width = 12;

	// Sticky status word, upper bits always zero
	localparam int status_width = 16;

	// Configuration tag
	localparam int tag_width = 8;

	// Timestamp bytes at the default counter width
	localparam int ts_bytes = 8;

	// Snapshot part of the frame: min/max pairs, status, tag_now, tag_old
	localparam int frame_bytes = 2 * adc_pkg::num_channels * adc_pkg::sample_width / 8
		+ status_width / 8 + 2 * tag_width / 8;

	// Whole readout, snapshot then timestamp
	localparam int total_bytes = frame_bytes + ts_bytes;

endpackage

/* design/slow_readout_ctrl.sv */
`timescale 1ns/1ps

module slow_readout_ctrl #(
	parameter int ts_width = 64
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            readout_req,
	input  logic [slow_pkg::event_width-1:0] cmp_event,
	input  logic [slow_pkg::tag_width-1:0]   tag_now,
	output logic                            slow_snap,
	output logic                            slow_op,
	output logic                            slow_valid,
	output logic                            slow_busy,
	output logic [slow_pkg::status_width-1:0] status_word,
	output logic [slow_pkg::tag_width-1:0]   tag_old
);

	// Byte count follows the timestamp width
	localparam int total_bytes = slow_pkg::frame_bytes + ts_width / 8;
	localparam int cnt_width = $clog2(total_bytes + 1);
	// Zero fill above the event lines
	localparam int pad_width = slow_pkg::status_width - slow_pkg::event_width;

	typedef enum logic [1:0] {
		st_idle,
		st_snap,
		st_stream
	} state_t;

	state_t               state;
	// Bytes still to present, including the current one
	logic [cnt_width-1:0] bytes_left;
	logic                 req_accept;

	// Requests count only while idle
	assign req_accept = readout_req && (state == st_idle);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			bytes_left <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (req_accept)
						state <= st_snap;
				end
				st_snap: begin
					// Frame loads at the end of this cycle
					state      <= st_stream;
					bytes_left <= cnt_width'(total_bytes);
				end
				st_stream: begin
					bytes_left <= bytes_left - 1'b1;
					if (bytes_left == cnt_width'(1))
						state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Decoded straight from the state register
	assign slow_snap  = (state == st_snap);
	assign slow_valid = (state == st_stream);
	assign slow_busy  = (state != st_idle);
	// Snap loads, every streaming cycle shifts
	assign slow_op    = slow_snap || slow_valid;

	// Sticky event word
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status_word <= '0;
		end else if (slow_snap) begin
			// Snap-cycle events open the next window
			status_word <= {{pad_width{1'b0}}, cmp_event};
		end else begin
			status_word <= status_word | {{pad_width{1'b0}}, cmp_event};
		end
	end

	// Tag at the previous snap, read by the chain before it updates
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tag_old <= '0;
		end else if (slow_snap) begin
			tag_old <= tag_now;
		end
	end

endmodule

/* design/slow_shell_top.sv */
`timescale 1ns/1ps

module slow_shell_top #(
	parameter int ts_width = slow_pkg::ts_bytes * 8
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  adc_pkg::sample_t                 a_field,
	input  adc_pkg::sample_t                 a_forward,
	input  adc_pkg::sample_t                 a_reflect,
	input  logic [slow_pkg::event_width-1:0] cmp_event,
	input  logic [slow_pkg::tag_width-1:0]   tag_now,
	input  logic                             readout_req,
	output logic [7:0]                       slow_out,
	output logic                             slow_valid,
	output logic                             slow_busy
);

	// Sequencing from the controller
	logic slow_snap;
	logic slow_op;

	// Channel order matches the frame: field, forward, reflect
	adc_pkg::sample_t samples [adc_pkg::num_channels];
	adc_pkg::sample_t adc_min [adc_pkg::num_channels];
	adc_pkg::sample_t adc_max [adc_pkg::num_channels];

	logic [slow_pkg::status_width-1:0] status_word;
	logic [slow_pkg::tag_width-1:0]    tag_old;
	logic [7:0]                        ts_byte;

	assign samples[0] = a_field;
	assign samples[1] = a_forward;
	assign samples[2] = a_reflect;

	slow_readout_ctrl #(
		.ts_width (ts_width)
	) u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.readout_req (readout_req),
		.cmp_event   (cmp_event),
		.tag_now     (tag_now),
		.slow_snap   (slow_snap),
		.slow_op     (slow_op),
		.slow_valid  (slow_valid),
		.slow_busy   (slow_busy),
		.status_word (status_word),
		.tag_old     (tag_old)
	);

	// One tracker per ADC stream
	for (genvar ch = 0; ch < adc_pkg::num_channels; ch++) begin : g_minmax
		adc_minmax u_minmax (
			.clk       (clk),
			.rst_n     (rst_n),
			.sample    (samples[ch]),
			.slow_snap (slow_snap),
			.adc_min   (adc_min[ch]),
			.adc_max   (adc_max[ch])
		);
	end

	timestamp_counter #(
		.ts_width (ts_width)
	) u_ts (
		.clk       (clk),
		.rst_n     (rst_n),
		.slow_snap (slow_snap),
		.slow_op   (slow_op),
		.ts_byte   (ts_byte)
	);

	// Frame first, then timestamp bytes from the tail
	slow_shift_chain u_chain (
		.clk         (clk),
		.rst_n       (rst_n),
		.slow_snap   (slow_snap),
		.slow_op     (slow_op),
		.adc_min     (adc_min),
		.adc_max     (adc_max),
		.status_word (status_word),
		.tag_now     (tag_now),
		.tag_old     (tag_old),
		.ts_byte     (ts_byte),
		.slow_out    (slow_out)
	);

endmodule

/* design/slow_shift_chain.sv */
`timescale 1ns/1ps

module slow_shift_chain (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              slow_snap,
	input  logic                              slow_op,
	input  adc_pkg::sample_t                  adc_min [adc_pkg::num_channels],
	input  adc_pkg::sample_t                  adc_max [adc_pkg::num_channels],
	input  logic [slow_pkg::status_width-1:0] status_word,
	input  logic [slow_pkg::tag_width-1:0]    tag_now,
	input  logic [slow_pkg::tag_width-1:0]    tag_old,
	input  logic [7:0]                        ts_byte,
	output logic [7:0]                        slow_out
);

	localparam int sw = adc_pkg::sample_width;
	localparam int tw = slow_pkg::tag_width;
	localparam int frame_bits = slow_pkg::frame_bytes * 8;

	// Assembled frame, first byte out at the top
	logic [frame_bits-1:0] frame_w;
	logic [frame_bits-1:0] chain;

	always_comb begin
		frame_w = '0;
		// Min then max per channel, channel 0 first
		for (int ch = 0; ch < adc_pkg::num_channels; ch++) begin
			frame_w[frame_bits-1-2*ch*sw -: sw] = adc_min[ch];
			frame_w[frame_bits-1-(2*ch+1)*sw -: sw] = adc_max[ch];
		end
		frame_w[slow_pkg::status_width+2*tw-1 -: slow_pkg::status_width] = status_word;
		frame_w[2*tw-1 -: tw] = tag_now;
		frame_w[tw-1:0] = tag_old;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			chain <= '0;
		end else if (slow_op) begin
			if (slow_snap) begin
				chain <= frame_w;
			end else begin
				// Timestamp bytes enter at the tail behind the frame
				chain <= {chain[frame_bits-9:0], ts_byte};
			end
		end
	end

	assign slow_out = chain[frame_bits-1 -: 8];

endmodule

/* design/timestamp_counter.sv */
`timescale 1ns/1ps

module timestamp_counter #(
	parameter int ts_width = 64
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       slow_snap,
	input  logic       slow_op,
	output logic [7:0] ts_byte
);

	// Free-running cycle count since reset release
	logic [ts_width-1:0] count;
	logic [ts_width-1:0] count_next;
	// Frozen copy, rotated one byte per op
	logic [ts_width-1:0] capture;

	assign count_next = count + 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			count <= count_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			capture <= '0;
		end else if (slow_op) begin
			if (slow_snap) begin
				// Include the snap edge itself in the count
				capture <= count_next;
			end else begin
				// Rotate left so the next lower byte comes to the top
				capture <= {capture[ts_width-9:0], capture[ts_width-1 -: 8]};
			end
		end
	end

	// Most significant byte goes first into the chain tail
	assign ts_byte = capture[ts_width-1 -: 8];

endmodule

/* sources.f */
design/adc_pkg.sv
design/slow_pkg.sv
design/adc_minmax.sv
design/timestamp_counter.sv
design/slow_readout_ctrl.sv
design/slow_shift_chain.sv
design/slow_shell_top.sv
verif/tb_clock_gen.sv
verif/slow_shell_properties.sv
verif/slow_shell_tb.sv

/* verif/slow_shell_properties.sv */
`timescale 1ns/1ps

module slow_shell_properties (
	input logic clk,
	input logic rst_n,
	input logic slow_valid,
	input logic slow_busy
);

	// Bytes only stream inside a busy period
	valid_implies_busy: assert property (
		@(posedge clk) disable iff (!rst_n) slow_valid |-> slow_busy
	) else $error("slow_valid high while slow_busy low");

	// Once streaming, valid holds until the busy period ends
	valid_holds_while_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		(slow_valid && slow_busy) |=> (slow_valid || !slow_busy)
	) else $error("slow_valid dropped inside a busy period");

	// Readout port quiet during reset
	quiet_in_reset: assert property (
		@(posedge clk) !rst_n |-> (!slow_valid && !slow_busy)
	) else $error("slow_valid or slow_busy high during reset");

endmodule

bind slow_shell_top slow_shell_properties u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.slow_valid (slow_valid),
	.slow_busy  (slow_busy)
);

/* verif/slow_shell_tb.sv */
`timescale 1ns/1ps

module slow_shell_tb;

	localparam int ts_width = 64;
	localparam int total_bytes = slow_pkg::frame_bytes + ts_width / 8;
	localparam int frame_bits = total_bytes * 8;
	// Readouts over all tests, plus room for reset and idle gaps
	localparam int num_readouts = 31;
	localparam int max_cycles = num_readouts * (total_bytes + 4) + 16 + 500;

	logic                             clk;
	logic                             rst_n;
	adc_pkg::sample_t                 a_field;
	adc_pkg::sample_t                 a_forward;
	adc_pkg::sample_t                 a_reflect;
	logic [slow_pkg::event_width-1:0] cmp_event;
	logic [slow_pkg::tag_width-1:0]   tag_now;
	logic                             readout_req;
	logic [7:0]                       slow_out;
	logic                             slow_valid;
	logic                             slow_busy;

	int seed = 32'h50b24d24;
	// Random samples and events each falling edge
	logic rand_en;
	int   errors;
	int   checks;
	int   tests;
	int   bytes_seen;
	int   frames_seen;
	int   frames_expected;
	int   test_err_base;
	int   run_cycles;

	// Reference model state
	logic [frame_bits-1:0]  exp_q [$];
	adc_pkg::sample_t       run_min [3];
	adc_pkg::sample_t       run_max [3];
	logic [15:0]            status_m;
	logic [7:0]             tag_old_m;
	logic [63:0]            cyc;
	logic                   armed;
	logic                   snap_pending;
	int                     busy_cnt;

	// Comparison state
	logic [frame_bits-1:0]  cur_frame;
	int                     byte_idx;

	tb_clock_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	slow_shell_top #(
		.ts_width (ts_width)
	) dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.a_field     (a_field),
		.a_forward   (a_forward),
		.a_reflect   (a_reflect),
		.cmp_event   (cmp_event),
		.tag_now     (tag_now),
		.readout_req (readout_req),
		.slow_out    (slow_out),
		.slow_valid  (slow_valid),
		.slow_busy   (slow_busy)
	);

	// Expected readout: min/max pairs, status, tags, then timestamp MSB first
	function automatic logic [frame_bits-1:0] build_frame(
		input logic [95:0] minmax,
		input logic [15:0] status,
		input logic [7:0]  tag_cur,
		input logic [7:0]  tag_prev,
		input logic [63:0] ts
	);
		return {minmax, status, tag_cur, tag_prev, ts};
	endfunction

	task automatic check(input string name, input int idx, input logic [63:0] exp,
		input logic [63:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("FAILED %s[%0d] expected %h got %h", name, idx, exp, got);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - test_err_base);
		test_err_base = errors;
	endtask

	// Called right after a falling edge, request sampled on the next rising edge
	task automatic request();
		readout_req = 1'b1;
		@(negedge clk);
		readout_req = 1'b0;
	endtask

	task automatic wait_idle();
		while (slow_busy)
			@(negedge clk);
	endtask

	task automatic readout();
		request();
		wait_idle();
	endtask

	always @(negedge clk) begin
		if (rand_en) begin
			a_field   = 16'($random(seed));
			a_forward = 16'($random(seed));
			a_reflect = 16'($random(seed));
			// Sparse events, most cycles quiet
			if (($random(seed) & 7) == 0)
				cmp_event = 12'($random(seed));
			else
				cmp_event = '0;
		end
	end

	// Shadow of the window, status, tag and timestamp at each rising edge
	always @(posedge clk) begin
		adc_pkg::sample_t s [3];
		s[0] = a_field;
		s[1] = a_forward;
		s[2] = a_reflect;
		if (!rst_n) begin
			cyc = '0;
			armed = 1'b0;
			snap_pending = 1'b0;
			busy_cnt = 0;
			status_m = '0;
			tag_old_m = '0;
			for (int ch = 0; ch < 3; ch++) begin
				run_min[ch] = '0;
				run_max[ch] = '0;
			end
		end else begin
			cyc++;
			if (snap_pending) begin
				// Frame carries the window that ends the cycle before this snap
				exp_q.push_back(build_frame({run_min[0], run_max[0], run_min[1], run_max[1],
					run_min[2], run_max[2]}, status_m, tag_now, tag_old_m, cyc));
				frames_expected++;
				for (int ch = 0; ch < 3; ch++) begin
					run_min[ch] = s[ch];
					run_max[ch] = s[ch];
				end
				status_m = {4'b0, cmp_event};
				tag_old_m = tag_now;
				snap_pending = 1'b0;
			end else begin
				for (int ch = 0; ch < 3; ch++) begin
					if (!armed || s[ch] < run_min[ch])
						run_min[ch] = s[ch];
					if (!armed || s[ch] > run_max[ch])
						run_max[ch] = s[ch];
				end
				status_m = status_m | {4'b0, cmp_event};
			end
			armed = 1'b1;
			// Snap cycle plus one cycle per byte
			if (busy_cnt > 0) begin
				busy_cnt--;
			end else if (readout_req) begin
				snap_pending = 1'b1;
				busy_cnt = total_bytes + 1;
			end
		end
	end

	// Output bytes are stable at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (slow_valid) begin
				if (byte_idx == 0) begin
					if (exp_q.size() == 0)
						report_error("slow_valid went high with no readout expected");
					else
						cur_frame = exp_q.pop_front();
				end
				check("slow_out", byte_idx, 64'(cur_frame[frame_bits-1-8*byte_idx -: 8]),
					64'(slow_out));
				bytes_seen++;
				byte_idx++;
				if (byte_idx == total_bytes) begin
					byte_idx = 0;
					frames_seen++;
				end
			end else if (byte_idx != 0) begin
				report_error($sformatf("slow_valid dropped after %0d bytes", byte_idx));
				byte_idx = 0;
			end
		end
	end

	always @(posedge clk) begin
		run_cycles++;
		if (run_cycles >= max_cycles) begin
			$display("Run stopped after %0d cycles without finishing", run_cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		int base;
		a_field = 16'sh1234;
		a_forward = -16'sd300;
		a_reflect = 16'sh0042;
		cmp_event = '0;
		tag_now = 8'h5a;
		readout_req = 1'b0;
		rand_en = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		bytes_seen = 0;
		frames_seen = 0;
		frames_expected = 0;
		test_err_base = 0;
		run_cycles = 0;
		byte_idx = 0;
		cur_frame = '0;
		@(posedge rst_n);
		@(negedge clk);

		// Constant inputs, first frame shows the constant window and a zero tag_old
		check("slow_busy", 0, 0, 64'(slow_busy));
		check("slow_valid", 0, 0, 64'(slow_valid));
		repeat (5) @(negedge clk);
		readout();
		readout();
		end_test("reset state");

		rand_en = 1'b1;
		repeat (40) @(negedge clk);
		readout();
		readout();
		end_test("min/max window");

		rand_en = 1'b0;
		for (int k = 0; k < slow_pkg::event_width; k += 3) begin
			cmp_event = 12'(1) << k;
			@(negedge clk);
			cmp_event = '0;
			@(negedge clk);
		end
		readout();
		readout();
		end_test("sticky status");

		for (int k = 0; k < 3; k++) begin
			tag_now = 8'h10 + 8'(k * 37);
			repeat (7 + k) @(negedge clk);
			readout();
		end
		end_test("tags and timestamp");

		// Extra request mid-stream must not add a frame
		base = bytes_seen;
		request();
		while (!slow_valid)
			@(negedge clk);
		repeat (5) @(negedge clk);
		request();
		wait_idle();
		check("byte_count", 0, total_bytes, 64'(bytes_seen - base));
		readout();
		end_test("request while busy");

		rand_en = 1'b1;
		for (int k = 0; k < 20; k++) begin
			tag_now = 8'($random(seed));
			readout();
		end
		rand_en = 1'b0;
		end_test("back-to-back readouts");

		repeat (4) @(negedge clk);
		check("frames", 0, 64'(frames_expected), 64'(frames_seen));
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real period_ns = 100.0,
	parameter int  reset_cycles = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2.0) clk = ~clk;
	end

	// Release on a falling edge, clear of the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule
